/* hw/id_branch_unit.sv */
module id_branch_unit (
    id_ctrl_if.consumer             ctrl,
    input  logic                    valid,
    input  logic [id_pkg::xlen-1:0] pc,
    input  logic [id_pkg::xlen-1:0] inst,
    input  logic [id_pkg::xlen-1:0] rs_value,
    input  logic [id_pkg::xlen-1:0] rt_value,
    output logic                    br_taken,
    output logic [id_pkg::xlen-1:0] br_target,
    output logic                    is_branch
);

    logic [id_pkg::xlen-1:0] pc_plus4;
    logic [id_pkg::xlen-1:0] br_offset;
    logic [id_pkg::xlen-1:0] jump_target;
    logic                    rs_eq_rt;
    logic                    cond;

    assign pc_plus4    = pc + 32'd4;
    assign br_offset   = {{14{inst[15]}}, inst[15:0], 2'b00};
    // region jump stays inside the 256 MB segment of the delay slot
    assign jump_target = {pc_plus4[31:28], inst[25:0], 2'b00};
    assign rs_eq_rt    = (rs_value == rt_value);

    always_comb begin
        case (ctrl.br_kind)
            id_pkg::BR_BEQ: cond = rs_eq_rt;
            id_pkg::BR_BNE: cond = !rs_eq_rt;
            id_pkg::BR_J,
            id_pkg::BR_JAL,
            id_pkg::BR_JR:  cond = 1'b1;
            default:        cond = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.br_kind)
            id_pkg::BR_BEQ,
            id_pkg::BR_BNE: br_target = pc_plus4 + br_offset;
            id_pkg::BR_JR:  br_target = rs_value;
            default:        br_target = jump_target;
        endcase
    end

    // empty stage never redirects fetch
    assign br_taken  = valid && cond;
    assign is_branch = valid && (ctrl.br_kind != id_pkg::BR_NONE);

endmodule

/* hw/id_ctrl_if.sv */
interface id_ctrl_if;

    // alu control
    id_pkg::alu_op_t   alu_op;
    logic              src1_is_sa;
    logic              src1_is_pc;
    id_pkg::src2_sel_t src2_sel;

    // write-back and memory control
    logic [id_pkg::reg_addr_w-1:0] dest;
    logic                          gr_we;
    logic                          mem_we;
    logic                          res_from_mem;

    id_pkg::br_kind_t br_kind;

    // exception status
    logic            ex;
    id_pkg::excode_t excode;

    modport decoder (
        output alu_op, src1_is_sa, src1_is_pc, src2_sel,
        output dest, gr_we, mem_we, res_from_mem,
        output br_kind, ex, excode
    );

    modport consumer (
        input alu_op, src1_is_sa, src1_is_pc, src2_sel,
        input dest, gr_we, mem_we, res_from_mem,
        input br_kind, ex, excode
    );

endinterface

/* hw/id_inst_decoder.sv */
module id_inst_decoder (
    input  logic [id_pkg::xlen-1:0] inst,
    input  logic                    fetch_ex,
    id_ctrl_if.decoder              ctrl
);

    id_pkg::opcode_t               op;
    id_pkg::funct_t                fn;
    logic [id_pkg::reg_addr_w-1:0] rt;
    logic [id_pkg::reg_addr_w-1:0] rd;
    logic                          known;
    logic                          is_syscall;
    logic                          is_break;

    assign op = id_pkg::opcode_t'(inst[31:26]);
    assign fn = id_pkg::funct_t'(inst[5:0]);
    assign rt = inst[20:16];
    assign rd = inst[15:11];

    always_comb begin
        // r-type add into rd unless told otherwise
        ctrl.alu_op       = id_pkg::ALU_ADD;
        ctrl.src1_is_sa   = 1'b0;
        ctrl.src1_is_pc   = 1'b0;
        ctrl.src2_sel     = id_pkg::SRC2_REG;
        ctrl.dest         = rd;
        ctrl.gr_we        = 1'b1;
        ctrl.mem_we       = 1'b0;
        ctrl.res_from_mem = 1'b0;
        ctrl.br_kind      = id_pkg::BR_NONE;
        known             = 1'b1;
        is_syscall        = 1'b0;
        is_break          = 1'b0;

        case (op)
            id_pkg::OP_SPECIAL: begin
                case (fn)
                    id_pkg::FN_ADDU: ctrl.alu_op = id_pkg::ALU_ADD;
                    id_pkg::FN_SUBU: ctrl.alu_op = id_pkg::ALU_SUB;
                    id_pkg::FN_SLT:  ctrl.alu_op = id_pkg::ALU_SLT;
                    id_pkg::FN_SLTU: ctrl.alu_op = id_pkg::ALU_SLTU;
                    id_pkg::FN_AND:  ctrl.alu_op = id_pkg::ALU_AND;
                    id_pkg::FN_OR:   ctrl.alu_op = id_pkg::ALU_OR;
                    id_pkg::FN_XOR:  ctrl.alu_op = id_pkg::ALU_XOR;
                    id_pkg::FN_NOR:  ctrl.alu_op = id_pkg::ALU_NOR;
                    id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
                        // shift amount comes from the sa field
                        ctrl.src1_is_sa = 1'b1;
                        if (fn == id_pkg::FN_SLL) begin
                            ctrl.alu_op = id_pkg::ALU_SLL;
                        end else if (fn == id_pkg::FN_SRL) begin
                            ctrl.alu_op = id_pkg::ALU_SRL;
                        end else begin
                            ctrl.alu_op = id_pkg::ALU_SRA;
                        end
                    end
                    id_pkg::FN_JR: begin
                        ctrl.br_kind = id_pkg::BR_JR;
                        ctrl.gr_we   = 1'b0;
                    end
                    id_pkg::FN_SYSCALL: begin
                        is_syscall = 1'b1;
                        ctrl.gr_we = 1'b0;
                    end
                    id_pkg::FN_BREAK: begin
                        is_break   = 1'b1;
                        ctrl.gr_we = 1'b0;
                    end
                    default: begin
                        known      = 1'b0;
                        ctrl.gr_we = 1'b0;
                    end
                endcase
            end
            id_pkg::OP_J: begin
                ctrl.br_kind = id_pkg::BR_J;
                ctrl.gr_we   = 1'b0;
            end
            id_pkg::OP_JAL: begin
                // link value is pc + 8 computed in execute
                ctrl.br_kind    = id_pkg::BR_JAL;
                ctrl.src1_is_pc = 1'b1;
                ctrl.src2_sel   = id_pkg::SRC2_EIGHT;
                ctrl.dest       = id_pkg::link_reg;
            end
            id_pkg::OP_BEQ: begin
                ctrl.br_kind = id_pkg::BR_BEQ;
                ctrl.gr_we   = 1'b0;
            end
            id_pkg::OP_BNE: begin
                ctrl.br_kind = id_pkg::BR_BNE;
                ctrl.gr_we   = 1'b0;
            end
            id_pkg::OP_ADDIU: begin
                ctrl.src2_sel = id_pkg::SRC2_SIMM;
                ctrl.dest     = rt;
            end
            id_pkg::OP_LUI: begin
                ctrl.alu_op   = id_pkg::ALU_LUI;
                ctrl.src2_sel = id_pkg::SRC2_SIMM;
                ctrl.dest     = rt;
            end
            id_pkg::OP_LW: begin
                ctrl.src2_sel     = id_pkg::SRC2_SIMM;
                ctrl.res_from_mem = 1'b1;
                ctrl.dest         = rt;
            end
            id_pkg::OP_SW: begin
                ctrl.src2_sel = id_pkg::SRC2_SIMM;
                ctrl.mem_we   = 1'b1;
                ctrl.gr_we    = 1'b0;
            end
            default: begin
                known      = 1'b0;
                ctrl.gr_we = 1'b0;
            end
        endcase

        // nop decodes as sll but writes nothing
        if (inst == '0) begin
            ctrl.gr_we = 1'b0;
        end
    end

    // fetch error first, then break, syscall, reserved instruction
    always_comb begin
        ctrl.ex     = 1'b1;
        ctrl.excode = id_pkg::EXC_ADEL;
        if (fetch_ex) begin
            ctrl.excode = id_pkg::EXC_ADEL;
        end else if (is_break) begin
            ctrl.excode = id_pkg::EXC_BP;
        end else if (is_syscall) begin
            ctrl.excode = id_pkg::EXC_SYS;
        end else if (!known) begin
            ctrl.excode = id_pkg::EXC_RI;
        end else begin
            ctrl.ex = 1'b0;
        end
    end

endmodule

/* hw/id_operand_read.sv */
module id_operand_read (
    input  logic                          clk,
    input  logic [id_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [id_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                          rf_we,
    input  logic [id_pkg::reg_addr_w-1:0] rf_waddr,
    input  logic [id_pkg::xlen-1:0]       rf_wdata,
    input  id_pkg::fwd_sel_t              rs_sel,
    input  id_pkg::fwd_sel_t              rt_sel,
    input  logic [id_pkg::xlen-1:0]       es_value,
    input  logic [id_pkg::xlen-1:0]       ms_value,
    output logic [id_pkg::xlen-1:0]       rs_value,
    output logic [id_pkg::xlen-1:0]       rt_value
);

    logic [id_pkg::xlen-1:0] rf [32];
    logic [id_pkg::xlen-1:0] rs_rdata;
    logic [id_pkg::xlen-1:0] rt_rdata;

    // register 0 is hardwired, so never written
    always_ff @(posedge clk) begin
        if (rf_we && (rf_waddr != '0)) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    assign rs_rdata = (rs_addr == '0) ? '0 : rf[rs_addr];
    assign rt_rdata = (rt_addr == '0) ? '0 : rf[rt_addr];

    // a write landing this cycle is covered by the forward selects
    function automatic logic [id_pkg::xlen-1:0] pick_operand(
        input id_pkg::fwd_sel_t        sel,
        input logic [id_pkg::xlen-1:0] rf_val,
        input logic [id_pkg::xlen-1:0] es_val,
        input logic [id_pkg::xlen-1:0] ms_val
    );
        logic [id_pkg::xlen-1:0] result;
        case (sel)
            id_pkg::FWD_ES: result = es_val;
            id_pkg::FWD_MS: result = ms_val;
            default:        result = rf_val;
        endcase
        return result;
    endfunction

    assign rs_value = pick_operand(rs_sel, rs_rdata, es_value, ms_value);
    assign rt_value = pick_operand(rt_sel, rt_rdata, es_value, ms_value);

endmodule

/* hw/id_pkg.sv */
package id_pkg;

    // datapath and register index widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // jal writes its return address here
    localparam logic [reg_addr_w-1:0] link_reg = 5'd31;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // function field under special, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SRL     = 6'h02,
        FN_SRA     = 6'h03,
        FN_JR      = 6'h08,
        FN_SYSCALL = 6'h0c,
        FN_BREAK   = 6'h0d,
        FN_ADDU    = 6'h21,
        FN_SUBU    = 6'h23,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_XOR     = 6'h26,
        FN_NOR     = 6'h27,
        FN_SLT     = 6'h2a,
        FN_SLTU    = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // second alu operand source
    typedef enum logic [1:0] {SRC2_REG, SRC2_SIMM, SRC2_EIGHT} src2_sel_t;

    typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_J, BR_JAL, BR_JR} br_kind_t;

    // operand source chosen by the hazard unit
    typedef enum logic [1:0] {FWD_RF, FWD_ES, FWD_MS} fwd_sel_t;

    // cause register exception codes
    typedef enum logic [4:0] {
        EXC_ADEL = 5'h04,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a
    } excode_t;

endpackage

/* hw/id_stage.sv */
module id_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    // from fetch
    input  logic                          fs_to_ds_valid,
    input  logic [id_pkg::xlen-1:0]       fs_inst,
    input  logic [id_pkg::xlen-1:0]       fs_pc,
    input  logic                          fs_ex,
    // handshake
    input  logic                          es_allowin,
    output logic                          ds_allowin,
    output logic                          ds_to_es_valid,
    input  logic                          stall,
    input  logic                          flush,
    // write-back port
    input  logic                          ws_rf_we,
    input  logic [id_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [id_pkg::xlen-1:0]       ws_rf_wdata,
    // forwarding
    input  id_pkg::fwd_sel_t              fwd_rs_sel,
    input  id_pkg::fwd_sel_t              fwd_rt_sel,
    input  logic [id_pkg::xlen-1:0]       fwd_es_value,
    input  logic [id_pkg::xlen-1:0]       fwd_ms_value,
    // to hazard unit
    output logic [id_pkg::reg_addr_w-1:0] rs_addr,
    output logic [id_pkg::reg_addr_w-1:0] rt_addr,
    // to fetch
    output logic                          br_taken,
    output logic [id_pkg::xlen-1:0]       br_target,
    output logic                          is_branch,
    // to execute
    output logic [id_pkg::xlen-1:0]       es_pc,
    output id_pkg::alu_op_t               es_alu_op,
    output logic                          es_src1_is_sa,
    output logic                          es_src1_is_pc,
    output id_pkg::src2_sel_t             es_src2_sel,
    output logic [15:0]                   es_imm,
    output logic [id_pkg::xlen-1:0]       es_rs_value,
    output logic [id_pkg::xlen-1:0]       es_rt_value,
    output logic [id_pkg::reg_addr_w-1:0] es_dest,
    output logic                          es_gr_we,
    output logic                          es_mem_we,
    output logic                          es_res_from_mem,
    output logic                          es_ex,
    output id_pkg::excode_t               es_excode
);

    logic                    ds_valid;
    logic [id_pkg::xlen-1:0] ds_inst;
    logic [id_pkg::xlen-1:0] ds_pc;
    logic                    ds_fs_ex;

    id_ctrl_if ctrl ();

    // the stage drains unless stalled or execute is full
    assign ds_allowin     = !ds_valid || (!stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !stall;

    // flush wins over a new arrival in the same edge
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst  <= fs_inst;
            ds_pc    <= fs_pc;
            ds_fs_ex <= fs_ex;
        end
    end

    assign rs_addr = ds_inst[25:21];
    assign rt_addr = ds_inst[20:16];

    id_operand_read u_operand_read (
        .clk      (clk),
        .rs_addr  (rs_addr),
        .rt_addr  (rt_addr),
        .rf_we    (ws_rf_we),
        .rf_waddr (ws_rf_waddr),
        .rf_wdata (ws_rf_wdata),
        .rs_sel   (fwd_rs_sel),
        .rt_sel   (fwd_rt_sel),
        .es_value (fwd_es_value),
        .ms_value (fwd_ms_value),
        .rs_value (es_rs_value),
        .rt_value (es_rt_value)
    );

    id_inst_decoder u_inst_decoder (
        .inst     (ds_inst),
        .fetch_ex (ds_fs_ex),
        .ctrl     (ctrl.decoder)
    );

    id_branch_unit u_branch_unit (
        .ctrl      (ctrl.consumer),
        .valid     (ds_valid),
        .pc        (ds_pc),
        .inst      (ds_inst),
        .rs_value  (es_rs_value),
        .rt_value  (es_rt_value),
        .br_taken  (br_taken),
        .br_target (br_target),
        .is_branch (is_branch)
    );

    assign es_pc           = ds_pc;
    assign es_imm          = ds_inst[15:0];
    assign es_alu_op       = ctrl.alu_op;
    assign es_src1_is_sa   = ctrl.src1_is_sa;
    assign es_src1_is_pc   = ctrl.src1_is_pc;
    assign es_src2_sel     = ctrl.src2_sel;
    assign es_dest         = ctrl.dest;
    assign es_res_from_mem = ctrl.res_from_mem;
    assign es_ex           = ctrl.ex;
    assign es_excode       = ctrl.excode;

    // no side effects leave an empty stage
    assign es_gr_we  = ds_valid && ctrl.gr_we;
    assign es_mem_we = ds_valid && ctrl.mem_we;

endmodule

/* sim.f */
hw/id_pkg.sv
hw/id_ctrl_if.sv
hw/id_operand_read.sv
hw/id_inst_decoder.sv
hw/id_branch_unit.sv
hw/id_stage.sv
verif/id_stage_assertions.sv
verif/tb_id_stage.sv

/* verif/id_stage_assertions.sv */
module id_stage_assertions (
    input logic              clk, rst_n, fs_to_ds_valid, fs_ex, es_allowin, ds_allowin,
    input logic              ds_to_es_valid, stall, flush, ws_rf_we, br_taken, is_branch,
    input logic              es_gr_we, es_mem_we, es_res_from_mem, es_ex,
    input logic              es_src1_is_sa, es_src1_is_pc,
    input logic [31:0]       fs_inst, fs_pc, ws_rf_wdata, fwd_es_value, fwd_ms_value,
    input logic [31:0]       br_target, es_pc, es_rs_value, es_rt_value,
    input logic [4:0]        ws_rf_waddr, es_dest, rs_addr, rt_addr,
    input logic [15:0]       es_imm,
    input id_pkg::fwd_sel_t  fwd_rs_sel, fwd_rt_sel,
    input id_pkg::alu_op_t   es_alu_op,
    input id_pkg::src2_sel_t es_src2_sel,
    input id_pkg::excode_t   es_excode
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]       shadow [32];
    logic              sh_valid;
    logic              sh_fs_ex;
    logic [31:0]       sh_inst;
    logic [31:0]       sh_pc;
    logic              exp_allowin;
    logic [5:0]        op;
    logic [5:0]        fn;
    logic              special, known, is_jr, is_sys, is_brk;
    logic              is_beq, is_bne, is_jmp, exp_taken, exp_is_branch;
    logic [31:0]       rf_rs, rf_rt;
    logic [31:0]       exp_rs, exp_rt, pc4, exp_target;
    logic [4:0]        exp_dest;
    logic              exp_gr_we;
    logic              exp_sa;
    id_pkg::src2_sel_t exp_src2;
    logic [15:0]       exp_dec, act_dec, dec_mask;
    logic [5:0]        exp_exc, act_exc;
    logic [33:0]       exp_br, act_br;
    logic [57:0]       exp_fields, act_fields;
    logic [64:0]       out_view, held;
    logic              failed = 1'b0;

    function automatic logic [31:0] operand_value(id_pkg::fwd_sel_t sel, logic [31:0] rf_val,
                                                  logic [31:0] es_val, logic [31:0] ms_val);
        case (sel)
            id_pkg::FWD_ES: return es_val;
            id_pkg::FWD_MS: return ms_val;
            default:        return rf_val;
        endcase
    endfunction

    function automatic id_pkg::alu_op_t expect_alu_op(logic [5:0] opc, logic [5:0] fnc);
        if (opc == 6'h0f) begin
            return id_pkg::ALU_LUI;
        end else if (opc != 6'h00) begin
            return id_pkg::ALU_ADD;
        end
        case (fnc)
            6'h23:   return id_pkg::ALU_SUB;
            6'h2a:   return id_pkg::ALU_SLT;
            6'h2b:   return id_pkg::ALU_SLTU;
            6'h24:   return id_pkg::ALU_AND;
            6'h25:   return id_pkg::ALU_OR;
            6'h26:   return id_pkg::ALU_XOR;
            6'h27:   return id_pkg::ALU_NOR;
            6'h00:   return id_pkg::ALU_SLL;
            6'h02:   return id_pkg::ALU_SRL;
            6'h03:   return id_pkg::ALU_SRA;
            default: return id_pkg::ALU_ADD;
        endcase
    endfunction

    // stage occupancy model from the handshake rules
    assign exp_allowin = !sh_valid || (!stall && es_allowin);
    assign out_view    = {es_pc, es_imm, es_dest, es_gr_we, es_mem_we, es_ex, es_excode,
                          es_alu_op};

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            sh_valid <= 1'b0;
        end else if (exp_allowin) begin
            sh_valid <= fs_to_ds_valid;
        end
        if (fs_to_ds_valid && exp_allowin) begin
            sh_inst  <= fs_inst;
            sh_pc    <= fs_pc;
            sh_fs_ex <= fs_ex;
        end
        if (ws_rf_we && (ws_rf_waddr != 5'd0)) begin
            shadow[ws_rf_waddr] <= ws_rf_wdata;
        end
        held <= out_view;
    end

    // reference decode straight from the instruction encodings
    assign op      = sh_inst[31:26];
    assign fn      = sh_inst[5:0];
    assign special = (op == 6'h00);
    assign is_jr   = special && (fn == 6'h08);
    assign is_sys  = special && (fn == 6'h0c);
    assign is_brk  = special && (fn == 6'h0d);
    assign known   = special ? (fn inside {6'h00, 6'h02, 6'h03, 6'h08, 6'h0c, 6'h0d, 6'h21,
                                           [6'h23:6'h27], 6'h2a, 6'h2b})
                             : (op inside {6'h02, 6'h03, 6'h04, 6'h05, 6'h09, 6'h0f, 6'h23,
                                           6'h2b});

    assign exp_dest  = (op == 6'h03) ? 5'd31
                     : (op inside {6'h09, 6'h0f, 6'h23}) ? sh_inst[20:16] : sh_inst[15:11];
    assign exp_gr_we = known && (sh_inst != 32'h0) && !is_jr && !is_sys && !is_brk
                       && !(op inside {6'h02, 6'h04, 6'h05, 6'h2b});
    assign exp_src2  = (op == 6'h03) ? id_pkg::SRC2_EIGHT
                     : (op inside {6'h09, 6'h0f, 6'h23, 6'h2b}) ? id_pkg::SRC2_SIMM
                     : id_pkg::SRC2_REG;
    // shifts take the sa field as first operand
    assign exp_sa    = special && (fn inside {6'h00, 6'h02, 6'h03});
    assign exp_dec   = {exp_sa, op == 6'h03, exp_dest, exp_gr_we, op == 6'h2b, op == 6'h23,
                        exp_src2, expect_alu_op(op, fn)};
    assign act_dec   = {es_src1_is_sa, es_src1_is_pc, es_dest, es_gr_we, es_mem_we,
                        es_res_from_mem, es_src2_sel, es_alu_op};
    // undefined words only promise no register or memory write
    assign dec_mask  = known ? 16'hffff : 16'h0180;

    assign exp_exc = sh_fs_ex ? {1'b1, 5'h04}
                   : is_brk   ? {1'b1, 5'h09}
                   : is_sys   ? {1'b1, 5'h08}
                   : !known   ? {1'b1, 5'h0a}
                   : 6'h00;
    assign act_exc = {es_ex, es_ex ? es_excode : 5'h00};

    assign exp_fields = {sh_pc, sh_inst[15:0], sh_inst[25:21], sh_inst[20:16]};
    assign act_fields = {es_pc, es_imm, rs_addr, rt_addr};

    assign rf_rs         = (sh_inst[25:21] == 5'd0) ? 32'h0 : shadow[sh_inst[25:21]];
    assign rf_rt         = (sh_inst[20:16] == 5'd0) ? 32'h0 : shadow[sh_inst[20:16]];
    assign exp_rs        = operand_value(fwd_rs_sel, rf_rs, fwd_es_value, fwd_ms_value);
    assign exp_rt        = operand_value(fwd_rt_sel, rf_rt, fwd_es_value, fwd_ms_value);
    assign pc4           = sh_pc + 32'd4;
    assign is_beq        = (op == 6'h04);
    assign is_bne        = (op == 6'h05);
    assign is_jmp        = (op == 6'h02) || (op == 6'h03) || is_jr;
    assign exp_is_branch = sh_valid && (is_beq || is_bne || is_jmp);
    assign exp_taken     = sh_valid && (is_jmp || (is_beq && (exp_rs == exp_rt))
                                       || (is_bne && (exp_rs != exp_rt)));
    assign exp_target    = is_jr ? exp_rs
                         : (is_beq || is_bne) ? pc4 + {{14{sh_inst[15]}}, sh_inst[15:0], 2'b00}
                         : {pc4[31:28], sh_inst[25:0], 2'b00};
    assign exp_br        = {exp_is_branch, exp_taken, exp_taken ? exp_target : 32'h0};
    assign act_br        = {is_branch, br_taken, br_taken ? br_target : 32'h0};

    operand_check: assert property (@(posedge clk) disable iff (!rst_n)
        ds_to_es_valid |-> ({es_rs_value, es_rt_value} == {exp_rs, exp_rt}))
        else begin
            $error("[FAIL] operand_read expected %h actual %h", $sampled({exp_rs, exp_rt}),
                   $sampled({es_rs_value, es_rt_value}));
            failed = 1'b1;
        end

    branch_check: assert property (@(posedge clk) disable iff (!rst_n) act_br == exp_br)
        else begin
            $error("[FAIL] branch expected %h actual %h", $sampled(exp_br), $sampled(act_br));
            failed = 1'b1;
        end

    decode_check: assert property (@(posedge clk) disable iff (!rst_n)
        sh_valid |-> ((act_dec & dec_mask) == (exp_dec & dec_mask)))
        else begin
            $error("[FAIL] decode expected %h actual %h", $sampled(exp_dec & dec_mask),
                   $sampled(act_dec & dec_mask));
            failed = 1'b1;
        end

    // pc, immediate and register indices of the held instruction
    field_check: assert property (@(posedge clk) disable iff (!rst_n)
        sh_valid |-> (act_fields == exp_fields))
        else begin
            $error("[FAIL] fields expected %h actual %h", $sampled(exp_fields),
                   $sampled(act_fields));
            failed = 1'b1;
        end

    exception_check: assert property (@(posedge clk) disable iff (!rst_n)
        sh_valid |-> (act_exc == exp_exc))
        else begin
            $error("[FAIL] exception expected %h actual %h", $sampled(exp_exc),
                   $sampled(act_exc));
            failed = 1'b1;
        end

    handshake_check: assert property (@(posedge clk) disable iff (!rst_n)
        {ds_allowin, ds_to_es_valid} == {exp_allowin, sh_valid && !stall})
        else begin
            $error("[FAIL] handshake expected %b actual %b",
                   $sampled({exp_allowin, sh_valid && !stall}),
                   $sampled({ds_allowin, ds_to_es_valid}));
            failed = 1'b1;
        end

    // back-pressure or stall freezes everything sent to execute
    hold_check: assert property (@(posedge clk) disable iff (!rst_n)
        sh_valid && (stall || !es_allowin) && !flush |=> (out_view == held))
        else begin
            $error("[FAIL] hold expected %h actual %h", $sampled(held), $sampled(out_view));
            failed = 1'b1;
        end

    flush_check: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ds_to_es_valid && !br_taken)
        else begin
            $error("[FAIL] flush expected 00 actual %b%b", $sampled(ds_to_es_valid),
                   $sampled(br_taken));
            failed = 1'b1;
        end

    reset_check: assert property (@(posedge clk)
        !rst_n |=> {ds_to_es_valid, br_taken, is_branch, es_gr_we, es_mem_we, ds_allowin}
                   == 6'b000001)
        else begin
            $error("[FAIL] reset expected 000001 actual %b", $sampled({ds_to_es_valid,
                   br_taken, is_branch, es_gr_we, es_mem_we, ds_allowin}));
            failed = 1'b1;
        end

endmodule

bind id_stage id_stage_assertions chk (.*);

/* verif/tb_id_stage.sv */
module tb_id_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 4;
    localparam int num_insts  = 3000;
    // at most eight cycles per instruction on average
    localparam int time_limit = num_insts * 8 * clk_period;

    localparam logic [5:0] funct_codes [14] = '{6'h21, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25,
        6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h08, 6'h0c, 6'h0d};
    localparam logic [5:0] op_codes [8] = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h09, 6'h0f, 6'h23,
        6'h2b};

    logic              clk;
    logic              rst_n;
    logic              fs_to_ds_valid, fs_ex, es_allowin, stall, flush, ws_rf_we;
    logic [31:0]       fs_inst, fs_pc, ws_rf_wdata, fwd_es_value, fwd_ms_value;
    logic [4:0]        ws_rf_waddr;
    id_pkg::fwd_sel_t  fwd_rs_sel, fwd_rt_sel;
    logic              ds_allowin, ds_to_es_valid, br_taken, is_branch;
    logic [4:0]        rs_addr, rt_addr, es_dest;
    logic [31:0]       br_target, es_pc, es_rs_value, es_rt_value;
    id_pkg::alu_op_t   es_alu_op;
    id_pkg::src2_sel_t es_src2_sel;
    logic [15:0]       es_imm;
    logic              es_src1_is_sa, es_src1_is_pc, es_gr_we, es_mem_we, es_res_from_mem;
    logic              es_ex;
    id_pkg::excode_t   es_excode;
    integer            seed = 32'h7de1;

    id_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // kept instructions with random fields, plus reserved words and nops
    task automatic random_inst(output logic [31:0] inst);
        logic [31:0] bits;
        int          pick;
        bits = $random(seed);
        pick = $unsigned($random(seed)) % 24;
        if (pick < 14) begin
            inst = {6'h00, bits[25:6], funct_codes[pick]};
        end else if (pick < 22) begin
            inst = {op_codes[pick - 14], bits[25:0]};
        end else if (pick == 22) begin
            inst = bits[0] ? {6'h00, bits[25:6], 6'h01} : {6'h3f, bits[25:0]};
        end else begin
            inst = 32'h0;
        end
    endtask

    task automatic random_controls();
        es_allowin   = ($random(seed) & 3) != 0;
        stall        = ($random(seed) & 7) == 0;
        flush        = ($random(seed) & 31) == 0;
        fwd_rs_sel   = id_pkg::fwd_sel_t'($unsigned($random(seed)) % 3);
        fwd_rt_sel   = id_pkg::fwd_sel_t'($unsigned($random(seed)) % 3);
        fwd_es_value = $random(seed);
        fwd_ms_value = $random(seed);
        ws_rf_we     = ($random(seed) & 1) == 1;
        ws_rf_waddr  = 5'($random(seed));
        ws_rf_wdata  = $random(seed);
    endtask

    initial begin
        logic [31:0] inst;
        logic        take;
        rst_n          = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_inst        = 32'h0;
        fs_pc          = 32'h0;
        fs_ex          = 1'b0;
        es_allowin     = 1'b1;
        stall          = 1'b0;
        flush          = 1'b0;
        ws_rf_we       = 1'b0;
        ws_rf_waddr    = 5'd0;
        ws_rf_wdata    = 32'h0;
        fwd_rs_sel     = id_pkg::FWD_RF;
        fwd_rt_sel     = id_pkg::FWD_RF;
        fwd_es_value   = 32'h0;
        fwd_ms_value   = 32'h0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // give every register a known random value
        for (int r = 1; r < 32; r++) begin
            ws_rf_we    = 1'b1;
            ws_rf_waddr = 5'(r);
            ws_rf_wdata = $random(seed);
            @(posedge clk);
            #1;
        end
        ws_rf_we = 1'b0;
        for (int i = 0; i < num_insts; i++) begin
            random_inst(inst);
            fs_inst        = inst;
            fs_pc          = $random(seed) & 32'hffff_fffc;
            fs_ex          = ($random(seed) & 15) == 0;
            fs_to_ds_valid = 1'b1;
            take           = 1'b0;
            while (!take) begin
                random_controls();
                @(negedge clk);
                take = ds_allowin;
                @(posedge clk);
                #1;
            end
        end
        fs_to_ds_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        if (dut0.chk.failed) begin
            $display("TEST FAILED");
            $fatal(1, "an assertion check failed during the run");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

    // stop at the first failing assertion
    initial begin
        wait (dut0.chk.failed === 1'b1);
        $display("TEST FAILED");
        $fatal(1, "an assertion check failed, stopping at the first error");
    end

    initial begin
        #(time_limit);
        $display("TEST FAILED");
        $fatal(1, "timeout, the stimulus did not finish within %0d ns", time_limit);
    end

endmodule
